// File: aembPkg.sv
package aembPkg;

   // instruction field widths.
   localparam int WordW = 32;
   localparam int OpcW  = 6;
   localparam int RegW  = 5;
   localparam int ImmW  = 16;
   localparam int AltW  = 11;

   // major opcodes recognized by the front end.
   typedef enum logic [OpcW-1:0] {
      ADD  = 6'o00,
      MUL  = 6'o20,
      BSF  = 6'o21,
      BRU  = 6'o46,
      BCC  = 6'o47,
      IMM  = 6'o54,
      RTD  = 6'o55,
      BRUI = 6'o56,
      BCCI = 6'o57
   } opcE;

   // words that the buffer can inject in place of the fetched one.
   localparam logic [WordW-1:0] xceOp = 32'hBA2D_0008; // brali r17, 0x08.
   localparam logic [WordW-1:0] intOp = 32'hB9CE_0010; // brali r14, 0x10.
   localparam logic [WordW-1:0] brkOp = 32'hBA0C_0018; // brali r16, 0x18.
   localparam logic [WordW-1:0] braOp = 32'h8800_0000; // or r0, r0, r0.

   // target of the injected interrupt branch.
   localparam logic [WordW-1:0] intVector = 32'h0000_0010;

endpackage

// File: aembFetch.sv
`timescale 1ns/100ps

module aembFetch #(
   parameter int AddrW = 32
) (
   input  logic             gclk,
   input  logic             grst,
   input  logic             gEna_i,
   input  logic             bra_i,
   input  logic [AddrW-1:0] brTarget_i,
   output logic [AddrW-1:0] iwbAdr_o
);

   logic [AddrW-1:0] pc;
   logic [AddrW-1:0] pcNext;

   // one word ahead, or the resolved target on a taken branch.
   always_comb begin
      if (bra_i) begin
         pcNext = brTarget_i;
      end else begin
         pcNext = pc + AddrW'(4);
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         pc <= '0;
      end else if (gEna_i) begin
         pc <= pcNext;
      end
   end

   assign iwbAdr_o = pc;

   // the target comes from the execute controller, so check alignment here.
   addrAligned: assert property (
      @(posedge gclk) disable iff (grst)
      iwbAdr_o[1:0] == 2'b00
   ) else $error("fetch address 0x%0h is not word aligned", iwbAdr_o);

endmodule

// File: aembIbuf.sv
`timescale 1ns/100ps

module aembIbuf (
   input  logic                        gclk,
   input  logic                        grst,
   input  logic                        gEna_i,
   input  logic                        oEna_i,
   input  logic [aembPkg::WordW-1:0]   iwbDat_i,
   input  logic                        bra_i,
   input  logic                        msrIe_i,
   input  logic                        msrBip_i,
   input  logic                        sysInt_i,
   output aembPkg::opcE                opc_o,
   output logic [aembPkg::RegW-1:0]    rd_o,
   output logic [aembPkg::RegW-1:0]    ra_o,
   output logic [aembPkg::RegW-1:0]    rb_o,
   output logic [aembPkg::AltW-1:0]    alt_o,
   output logic [aembPkg::WordW-1:0]   simm_o,
   output logic                        stall_o
);

   logic [1:0]                  syncInt;
   logic                        pendInt;
   logic                        injInt;
   logic                        fImm;
   logic                        fRtd;
   logic                        fBru;
   logic                        fBcc;
   logic                        xMulti;
   logic [aembPkg::OpcW-1:0]    xOpc;
   logic [aembPkg::WordW-1:0]   xIreg;
   logic [aembPkg::WordW-1:0]   xSimm;
   logic [aembPkg::ImmW-1:0]    imm;

   // interrupt synchronizer and pending latch.
   always_ff @(posedge gclk) begin
      if (grst) begin
         syncInt <= 2'b00;
         pendInt <= 1'b0;
      end else begin
         syncInt <= {syncInt[0], sysInt_i};
         if (gEna_i && injInt) begin
            pendInt <= 1'b0; // taken by this slot.
         end else begin
            pendInt <= (pendInt | syncInt[1]) & msrIe_i;
         end
      end
   end

   // class of the instruction currently decoded.
   assign fImm = (opc_o == aembPkg::IMM);
   assign fRtd = (opc_o == aembPkg::RTD);
   assign fBru = (opc_o == aembPkg::BRU) || (opc_o == aembPkg::BRUI);
   assign fBcc = (opc_o == aembPkg::BCC) || (opc_o == aembPkg::BCCI);

   // never split an IMM pair or a branch from its delay slot.
   assign injInt = pendInt && !msrBip_i && !bra_i && !fImm && !fRtd && !fBru && !fBcc;

   always_comb begin
      if (bra_i) begin
         xIreg = aembPkg::braOp; // flush the word behind the delay slot.
      end else if (injInt) begin
         xIreg = aembPkg::intOp;
      end else begin
         xIreg = iwbDat_i;
      end
   end

   always_comb begin
      if (fImm && !bra_i) begin
         xSimm = {imm, xIreg[aembPkg::ImmW-1:0]}; // prefix gives the high half.
      end else begin
         xSimm = {{aembPkg::ImmW{xIreg[aembPkg::ImmW-1]}}, xIreg[aembPkg::ImmW-1:0]};
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         opc_o <= aembPkg::ADD;
      end else if (gEna_i) begin
         opc_o <= aembPkg::opcE'(xIreg[31:26]);
      end
   end

   always_ff @(posedge gclk) begin
      if (gEna_i) begin
         rd_o   <= xIreg[25:21];
         ra_o   <= xIreg[20:16];
         imm    <= xIreg[15:0];
         simm_o <= xSimm;
      end
   end

   assign rb_o  = imm[15:11];
   assign alt_o = imm[10:0];

   // immediate forms differ from the register forms only in bit 3.
   assign xOpc   = xIreg[31:26] & 6'o67;
   assign xMulti = (xOpc == aembPkg::MUL) || (xOpc == aembPkg::BSF);

   always_ff @(posedge gclk) begin
      if (grst) begin
         stall_o <= 1'b0;
      end else if (stall_o) begin
         stall_o <= !oEna_i;
      end else begin
         stall_o <= gEna_i && xMulti; // rises with the MUL in the decode latch.
      end
   end

   // a multi-cycle word is accepted only while no stall is held.
   stallNoRestart: assert property (
      @(posedge gclk) disable iff (grst)
      gEna_i && xMulti |-> !stall_o
   ) else $error("stall started while a stall is already held");

endmodule

// File: aembExec.sv
`timescale 1ns/100ps

module aembExec #(
   parameter int MulCycles = 2
) (
   input  logic                        gclk,
   input  logic                        grst,
   input  aembPkg::opcE                opc_i,
   input  logic [aembPkg::WordW-1:0]   simm_i,
   input  logic [aembPkg::WordW-1:0]   pc_i,
   input  logic                        stall_i,
   output logic                        gEna_o,
   output logic                        oEna_o,
   output logic                        bra_o,
   output logic [aembPkg::WordW-1:0]   brTarget_o
);

   localparam int CntW = $clog2(MulCycles + 1);

   typedef enum logic [1:0] {
      IDLE,
      BUSY,
      DONE
   } stateE;

   stateE           state;
   logic [CntW-1:0] cnt;
   logic            takeBra;
   logic            intJmp;

   // multi-cycle timer, first stall cycle is spent in IDLE.
   always_ff @(posedge gclk) begin
      if (grst) begin
         state <= IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (stall_i) begin
                  cnt   <= CntW'(1);
                  state <= (MulCycles > 1) ? BUSY : DONE;
               end
            end
            BUSY: begin
               if (cnt == CntW'(MulCycles - 1)) begin
                  state <= DONE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            DONE:    state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   assign oEna_o = (state == DONE);
   assign gEna_o = !stall_i;

   assign takeBra = !stall_i && (opc_i == aembPkg::BRUI);

   // the injected interrupt branch is absolute.
   assign intJmp = (simm_i == {{16{aembPkg::intOp[15]}}, aembPkg::intOp[15:0]});

   always_ff @(posedge gclk) begin
      if (grst) begin
         bra_o <= 1'b0;
      end else begin
         bra_o <= takeBra;
      end
   end

   always_ff @(posedge gclk) begin
      if (takeBra) begin
         brTarget_o <= intJmp ? aembPkg::intVector : pc_i + simm_i;
      end
   end

   braNoStall: assert property (
      @(posedge gclk) disable iff (grst)
      bra_o |-> !stall_i
   ) else $error("taken branch during a stall");

   // release only ends a stall raised by the buffer.
   oEnaInStall: assert property (
      @(posedge gclk) disable iff (grst)
      oEna_o |-> stall_i
   ) else $error("stall release without a stall");

endmodule

// File: aembFrontEnd.sv
`timescale 1ns/100ps

module aembFrontEnd #(
   parameter int AddrW     = 32,
   parameter int MulCycles = 2
) (
   input  logic                        gclk,
   input  logic                        grst,
   input  logic [aembPkg::WordW-1:0]   iwbDat_i,
   input  logic                        msrIe_i,
   input  logic                        sysInt_i,
   output logic [AddrW-1:0]            iwbAdr_o,
   output logic                        iwbStb_o,
   output aembPkg::opcE                opc_o,
   output logic [aembPkg::RegW-1:0]    rd_o,
   output logic [aembPkg::RegW-1:0]    ra_o,
   output logic [aembPkg::WordW-1:0]   simm_o,
   output logic                        stall_o,
   output logic                        bra_o
);

   logic                        gEna;
   logic                        oEna;
   logic                        msrBip;
   logic [aembPkg::WordW-1:0]   brTarget;
   logic [aembPkg::WordW-1:0]   decPc;

   assign iwbStb_o = 1'b1; // memory answers every cycle.
   assign msrBip   = 1'b0;

   // decode trails the fetch address by one word.
   assign decPc = aembPkg::WordW'(iwbAdr_o) - 32'd4;

   aembFetch #(
      .AddrW(AddrW)
   ) i_aembFetch (
      .gclk       (gclk),
      .grst       (grst),
      .gEna_i     (gEna),
      .bra_i      (bra_o),
      .brTarget_i (brTarget[AddrW-1:0]),
      .iwbAdr_o   (iwbAdr_o)
   );

   aembIbuf i_aembIbuf (
      .gclk     (gclk),
      .grst     (grst),
      .gEna_i   (gEna),
      .oEna_i   (oEna),
      .iwbDat_i (iwbDat_i),
      .bra_i    (bra_o),
      .msrIe_i  (msrIe_i),
      .msrBip_i (msrBip),
      .sysInt_i (sysInt_i),
      .opc_o    (opc_o),
      .rd_o     (rd_o),
      .ra_o     (ra_o),
      .rb_o     (),
      .alt_o    (),
      .simm_o   (simm_o),
      .stall_o  (stall_o)
   );

   aembExec #(
      .MulCycles(MulCycles)
   ) i_aembExec (
      .gclk       (gclk),
      .grst       (grst),
      .opc_i      (opc_o),
      .simm_i     (simm_o),
      .pc_i       (decPc),
      .stall_i    (stall_o),
      .gEna_o     (gEna),
      .oEna_o     (oEna),
      .bra_o      (bra_o),
      .brTarget_o (brTarget)
   );

endmodule

// File: aembChecker.sv
`timescale 1ns/100ps

module aembChecker (
   input  logic        gclk,
   input  logic        grst,
   input  logic        valid_i,
   input  logic        fields_i,
   input  logic [31:0] expAdr_i,
   input  logic [5:0]  expOpc_i,
   input  logic [4:0]  expRd_i,
   input  logic [4:0]  expRa_i,
   input  logic [31:0] expSimm_i,
   input  logic        expStall_i,
   input  logic        expBra_i,
   input  logic [31:0] adr_i,
   input  logic        stb_i,
   input  logic [5:0]  opc_i,
   input  logic [4:0]  rd_i,
   input  logic [4:0]  ra_i,
   input  logic [31:0] simm_i,
   input  logic        stall_i,
   input  logic        bra_i,
   output int          errCnt_o,
   output int          chkCnt_o
);

   task automatic compare(input string name, input logic [31:0] expVal,
                          input logic [31:0] gotVal);
      if (gotVal !== expVal) begin
         errCnt_o = errCnt_o + 1;
         $display("ERROR t=%0t %s expected 0x%0h got 0x%0h", $time, name, expVal, gotVal);
      end
   endtask

   initial begin
      errCnt_o = 0;
      chkCnt_o = 0;
   end

   // outputs are sampled before the edge updates them.
   always @(posedge gclk) begin
      if (valid_i && !grst) begin
         compare("iwbAdr_o", expAdr_i, adr_i);
         compare("iwbStb_o", 32'd1, 32'(stb_i));
         compare("stall_o", 32'(expStall_i), 32'(stall_i));
         compare("bra_o", 32'(expBra_i), 32'(bra_i));
         compare("opc_o", 32'(expOpc_i), 32'(opc_i));
         if (fields_i) begin // decode fields are not reset.
            compare("rd_o", 32'(expRd_i), 32'(rd_i));
            compare("ra_o", 32'(expRa_i), 32'(ra_i));
            compare("simm_o", expSimm_i, simm_i);
         end
         chkCnt_o = chkCnt_o + 1;
      end
   end

endmodule

// File: tb_aembFrontEnd.sv
`timescale 1ns/100ps

module tb_aembFrontEnd;

   logic        gclk;
   logic        grst;
   logic [31:0] iwbDat;
   logic        msrIe;
   logic        sysInt;
   logic [31:0] iwbAdr;
   logic        iwbStb;
   logic [5:0]  opc;
   logic [4:0]  rd;
   logic [4:0]  ra;
   logic [31:0] simm;
   logic        stall;
   logic        bra;

   logic        valid;
   logic        fields;
   logic [31:0] expAdr;
   logic [5:0]  expOpc;
   logic [4:0]  expRd;
   logic [4:0]  expRa;
   logic [31:0] expSimm;
   logic        expStall;
   logic        expBra;
   int          errCnt;
   int          chkCnt;

   logic [31:0] mem [0:63]; // instruction memory, one word per entry.

   // stimulus table, one entry per cycle after reset.
   logic        qInt[$];
   logic        qIe[$];
   logic [31:0] qAdr[$];
   int          qSrc[$]; // decoded address, -1 flush word, -2 interrupt word, -3 none.
   logic [5:0]  qOpc[$];
   logic [31:0] qSimm[$];
   logic        qStall[$];
   logic        qBra[$];

   assign iwbDat = mem[iwbAdr[7:2]]; // same-cycle answer.

   aembFrontEnd #(.AddrW(32), .MulCycles(2)) i_aembFrontEnd (
      .gclk(gclk), .grst(grst), .iwbDat_i(iwbDat), .msrIe_i(msrIe), .sysInt_i(sysInt),
      .iwbAdr_o(iwbAdr), .iwbStb_o(iwbStb), .opc_o(opc), .rd_o(rd), .ra_o(ra),
      .simm_o(simm), .stall_o(stall), .bra_o(bra)
   );

   aembChecker i_aembChecker (
      .gclk(gclk), .grst(grst), .valid_i(valid), .fields_i(fields), .expAdr_i(expAdr),
      .expOpc_i(expOpc), .expRd_i(expRd), .expRa_i(expRa), .expSimm_i(expSimm),
      .expStall_i(expStall), .expBra_i(expBra), .adr_i(iwbAdr), .stb_i(iwbStb),
      .opc_i(opc), .rd_i(rd), .ra_i(ra), .simm_i(simm), .stall_i(stall), .bra_i(bra),
      .errCnt_o(errCnt), .chkCnt_o(chkCnt)
   );

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;
   end

   function automatic logic [31:0] makeWord(input logic [5:0] op, input logic [15:0] imm);
      logic [9:0] regs;
      regs = 10'($urandom()); // register fields are don't care.
      return {op, regs, imm};
   endfunction

   task automatic addRow(input logic si, input logic ie, input logic [31:0] adr,
                         input int src, input logic [5:0] op, input logic [31:0] sv,
                         input logic st, input logic br);
      qInt.push_back(si);
      qIe.push_back(ie);
      qAdr.push_back(adr);
      qSrc.push_back(src);
      qOpc.push_back(op);
      qSimm.push_back(sv);
      qStall.push_back(st);
      qBra.push_back(br);
   endtask

   task automatic applyRow(input int r);
      logic [31:0] word;
      sysInt   = qInt[r];
      msrIe    = qIe[r];
      expAdr   = qAdr[r];
      expOpc   = qOpc[r];
      expSimm  = qSimm[r];
      expStall = qStall[r];
      expBra   = qBra[r];
      fields   = (qSrc[r] != -3);
      if (qSrc[r] == -1) word = aembPkg::braOp;
      else if (qSrc[r] == -2) word = aembPkg::intOp;
      else if (qSrc[r] >= 0) word = mem[qSrc[r] / 4];
      else word = '0;
      expRd = word[25:21];
      expRa = word[20:16];
      valid = 1'b1;
   endtask

   initial begin
      int waitCyc;
      void'($urandom(32'hf5f4f193));
      grst     = 1'b1;
      msrIe    = 1'b0;
      sysInt   = 1'b0;
      valid    = 1'b0;
      fields   = 1'b0;
      expAdr   = '0;
      expOpc   = '0;
      expRd    = '0;
      expRa    = '0;
      expSimm  = '0;
      expStall = 1'b0;
      expBra   = 1'b0;
      for (int i = 0; i < 64; i++) begin
         mem[i] = makeWord(aembPkg::ADD, 16'(i * 4)); // imm follows the address.
      end
      mem[0] = makeWord(aembPkg::ADD, 16'h0005);
      mem[1] = makeWord(aembPkg::ADD, 16'h8001);
      mem[2] = makeWord(aembPkg::IMM, 16'h1234);
      mem[3] = makeWord(aembPkg::ADD, 16'h5678);
      mem[4] = makeWord(aembPkg::ADD, 16'h0777);
      mem[5] = makeWord(aembPkg::MUL, 16'h0003);
      mem[6] = makeWord(aembPkg::ADD, 16'h0001);
      mem[7] = makeWord(aembPkg::BRUI, 16'h0020); // to 0x3c.
      mem[8] = makeWord(aembPkg::ADD, 16'h0002);
      mem[9] = makeWord(aembPkg::ADD, 16'h0bad);

      addRow(0, 0, 32'h00, -3,   aembPkg::ADD,  32'h0,        0, 0);
      addRow(1, 0, 32'h04, 'h00, aembPkg::ADD,  32'h5,        0, 0); // masked interrupt.
      addRow(1, 0, 32'h08, 'h04, aembPkg::ADD,  32'hffff8001, 0, 0);
      addRow(0, 0, 32'h0c, 'h08, aembPkg::IMM,  32'h1234,     0, 0);
      addRow(0, 0, 32'h10, 'h0c, aembPkg::ADD,  32'h12345678, 0, 0);
      addRow(0, 0, 32'h14, 'h10, aembPkg::ADD,  32'h777,      0, 0);
      addRow(0, 0, 32'h18, 'h14, aembPkg::MUL,  32'h3,        1, 0);
      addRow(0, 0, 32'h18, 'h14, aembPkg::MUL,  32'h3,        1, 0);
      addRow(0, 0, 32'h18, 'h14, aembPkg::MUL,  32'h3,        1, 0);
      addRow(0, 0, 32'h18, 'h14, aembPkg::MUL,  32'h3,        0, 0);
      addRow(0, 0, 32'h1c, 'h18, aembPkg::ADD,  32'h1,        0, 0);
      addRow(0, 0, 32'h20, 'h1c, aembPkg::BRUI, 32'h20,       0, 0);
      addRow(0, 0, 32'h24, 'h20, aembPkg::ADD,  32'h2,        0, 1);
      addRow(0, 0, 32'h3c, -1,   aembPkg::braOp[31:26], 32'h0, 0, 0);
      addRow(0, 1, 32'h40, 'h3c, aembPkg::ADD,  32'h3c,       0, 0);
      addRow(1, 1, 32'h44, 'h40, aembPkg::ADD,  32'h40,       0, 0);
      addRow(0, 1, 32'h48, 'h44, aembPkg::ADD,  32'h44,       0, 0);
      addRow(0, 1, 32'h4c, 'h48, aembPkg::ADD,  32'h48,       0, 0);
      addRow(0, 1, 32'h50, 'h4c, aembPkg::ADD,  32'h4c,       0, 0);
      addRow(0, 1, 32'h54, -2,   aembPkg::BRUI, 32'h10,       0, 0);
      addRow(0, 1, 32'h58, 'h54, aembPkg::ADD,  32'h54,       0, 1);
      addRow(0, 1, 32'h10, -1,   aembPkg::braOp[31:26], 32'h0, 0, 0);
      addRow(0, 1, 32'h14, 'h10, aembPkg::ADD,  32'h777,      0, 0);

      repeat (3) @(posedge gclk);
      @(negedge gclk);
      grst = 1'b0;
      for (int r = 0; r < qAdr.size(); r++) begin
         applyRow(r);
         @(negedge gclk);
      end
      valid = 1'b0;

      waitCyc = 0;
      while (chkCnt != qAdr.size() && waitCyc < 10) begin
         @(negedge gclk);
         waitCyc++;
      end
      if (chkCnt != qAdr.size()) begin
         $display("timeout: checker compared %0d of %0d rows", chkCnt, qAdr.size());
         $display("=== FAIL ===");
      end else begin
         $display("checks %0d errors %0d", chkCnt, errCnt);
         if (errCnt == 0) begin
            $display("=== PASS ===");
         end else begin
            $display("=== FAIL ===");
         end
      end
      $finish;
   end

endmodule

// File: vlog.f
aembPkg.sv
aembFetch.sv
aembIbuf.sv
aembExec.sv
aembFrontEnd.sv
aembChecker.sv
tb_aembFrontEnd.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module tb_aembFrontEnd \
   -f vlog.f \
   -o simv

./obj_dir/simv | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation passed"
